/* rtl/ms6205_pkg.sv */
package ms6205_pkg;

    // Screen views, in the encoding the trainer firmware expects.
    typedef enum logic [2:0] {
        view_restart = 3'b000,
        view_iram    = 3'b001,
        view_dram    = 3'b010,
        view_cin     = 3'b011,
        view_cout    = 3'b100
    } view_t;

    typedef logic [39:0] key_state_t; // one bit per key, high while pressed.

    // Positions of the view keys in the keyboard state word.
    localparam int key_iram     = 10;
    localparam int key_dram     = 11;
    localparam int key_cin      = 12;
    localparam int key_cout     = 13;
    localparam int key_hard_rst = 39;

    // One character-cell write.
    typedef struct packed {
        logic [7:0] addr; // linear cell index, row major.
        logic [6:0] code; // ascii.
    } cell_t;

    // Word on the external display bus.
    typedef struct packed {
        logic [7:0] addr;
        logic [7:0] data; // zero top bit over the inverted code.
    } bus_t;

    localparam logic [6:0] space_code = 7'h20;

    localparam logic [2:0] dpc_marker_state = 3'd2; // processor state that lights the marker.

endpackage

/* rtl/view_controller.sv */
`timescale 1ns/10ps

module view_controller #(
    parameter int columns = 16,
    parameter int rows = 10
) (
    input  logic                    clock_1ms,
    input  logic                    rst,
    input  ms6205_pkg::key_state_t  keys,
    input  logic [2:0]              dpc_state,
    input  ms6205_pkg::cell_t       host_cell,
    input  logic                    host_valid,
    output logic                    host_ready,
    output ms6205_pkg::cell_t       push_cell,
    output logic                    push_valid,
    input  logic                    push_ready,
    output ms6205_pkg::view_t       view,
    output logic                    marker
);

    localparam int max_pos = columns * rows;
    localparam logic [7:0] last_addr = 8'(max_pos - 1);

    logic [7:0]         sweep_addr;
    logic               in_restart;
    logic               push_fire;
    logic               sweep_done;
    ms6205_pkg::view_t  next_view;

    assign in_restart = (view == ms6205_pkg::view_restart);
    assign push_fire  = push_valid && push_ready;
    assign sweep_done = in_restart && push_fire && (sweep_addr == last_addr);

    // keys are priority encoded; the sweep must finish before any key counts.
    always_comb begin
        next_view = view;
        if (in_restart) begin
            if (sweep_done) begin
                next_view = ms6205_pkg::view_iram;
            end
        end else if (keys[ms6205_pkg::key_iram]) begin
            next_view = ms6205_pkg::view_iram;
        end else if (keys[ms6205_pkg::key_dram]) begin
            next_view = ms6205_pkg::view_dram;
        end else if (keys[ms6205_pkg::key_cin]) begin
            next_view = ms6205_pkg::view_cin;
        end else if (keys[ms6205_pkg::key_cout]) begin
            next_view = ms6205_pkg::view_cout;
        end else if (keys[ms6205_pkg::key_hard_rst]) begin
            next_view = ms6205_pkg::view_restart;
        end
    end

    always_comb begin
        if (in_restart) begin
            push_cell.addr = sweep_addr;
            push_cell.code = ms6205_pkg::space_code;
            push_valid     = 1'b1;
        end else begin
            push_cell.addr = host_cell.addr;
            push_cell.code = (host_cell.code == 7'd0) ? ms6205_pkg::space_code : host_cell.code;
            push_valid     = host_valid;
        end
    end

    assign host_ready = !in_restart && push_ready; // host is shut out during the clear sweep.

    assign marker = (view == ms6205_pkg::view_iram) && (dpc_state == ms6205_pkg::dpc_marker_state);

    always_ff @(posedge clock_1ms) begin
        if (rst) begin
            view       <= ms6205_pkg::view_restart;
            sweep_addr <= 8'd0;
        end else begin
            view <= next_view;
            if (in_restart && push_fire) begin
                sweep_addr <= sweep_done ? 8'd0 : sweep_addr + 8'd1; // wraps so the next sweep starts at 0.
            end
        end
    end

    // the clear sweep never runs past the last cell of the screen.
    a_sweep_in_range: assert property (
        @(posedge clock_1ms) disable iff (rst)
        (push_valid && in_restart) |-> (int'(push_cell.addr) < max_pos)
    );

endmodule

/* rtl/cell_fifo.sv */
`timescale 1ns/10ps

module cell_fifo #(
    parameter int fifo_depth = 8
) (
    input  logic               clock_1ms,
    input  logic               rst,
    input  ms6205_pkg::cell_t  push_cell,
    input  logic               push_valid,
    output logic               push_ready,
    output ms6205_pkg::cell_t  pop_cell,
    output logic               pop_valid,
    input  logic               pop_ready
);

    localparam int ptr_w = $clog2(fifo_depth);
    localparam logic [ptr_w:0] full_count = (ptr_w + 1)'(fifo_depth);

    ms6205_pkg::cell_t  mem [fifo_depth];
    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [ptr_w:0]     count;
    logic               full;
    logic               push_fire;
    logic               pop_fire;

    assign full      = (count == full_count);
    assign pop_valid = (count != '0);
    assign pop_cell  = mem[rd_ptr];

    // a full buffer still takes a cell in the cycle the writer frees a slot.
    assign push_ready = !full || pop_ready;
    assign push_fire  = push_valid && push_ready;
    assign pop_fire   = pop_valid && pop_ready;

    always_ff @(posedge clock_1ms) begin
        if (push_fire) begin
            mem[wr_ptr] <= push_cell;
        end
    end

    always_ff @(posedge clock_1ms) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_fire) begin
                wr_ptr <= wr_ptr + 1'b1; // depth is a power of two, so pointers wrap by themselves.
            end
            if (pop_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_fire, pop_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_count_bound: assert property (
        @(posedge clock_1ms) disable iff (rst)
        count <= full_count
    );

    // a push into a full buffer only lands alongside a pop, so the buffer stays exactly full.
    a_no_overwrite: assert property (
        @(posedge clock_1ms) disable iff (rst)
        (push_fire && full) |=> full
    );

endmodule

/* rtl/display_writer.sv */
`timescale 1ns/10ps

module display_writer (
    input  logic               clock_1ms,
    input  logic               rst,
    input  ms6205_pkg::cell_t  pop_cell,
    input  logic               pop_valid,
    output logic               pop_ready,
    output ms6205_pkg::bus_t   disp_bus,
    output logic               disp_req,
    input  logic               disp_ack
);

    typedef enum logic [1:0] {
        st_idle,
        st_wait_ack_hi,
        st_wait_ack_lo
    } state_t;

    state_t state;

    assign pop_ready = (state == st_idle); // ack is already low whenever we are back in idle.

    always_ff @(posedge clock_1ms) begin
        if (rst) begin
            state    <= st_idle;
            disp_req <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (pop_valid) begin
                        disp_req <= 1'b1;
                        state    <= st_wait_ack_hi;
                    end
                end
                st_wait_ack_hi: begin
                    if (disp_ack) begin
                        disp_req <= 1'b0;
                        state    <= st_wait_ack_lo;
                    end
                end
                st_wait_ack_lo: begin
                    if (!disp_ack) begin
                        state <= st_idle; // write complete.
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // the bus word is loaded only on a pop, so it holds for the whole handshake.
    always_ff @(posedge clock_1ms) begin
        if (pop_valid && pop_ready) begin
            disp_bus.addr <= pop_cell.addr;
            disp_bus.data <= {1'b0, ~pop_cell.code};
        end
    end

    a_bus_stable: assert property (
        @(posedge clock_1ms) disable iff (rst)
        (disp_req || disp_ack) |=> $stable(disp_bus)
    );

    a_req_holds: assert property (
        @(posedge clock_1ms) disable iff (rst)
        (disp_req && !disp_ack) |=> disp_req
    );

endmodule

/* rtl/ms6205_top.sv */
`timescale 1ns/10ps

module ms6205_top #(
    parameter int columns = 16,
    parameter int rows = 10,
    parameter int fifo_depth = 8
) (
    input  logic                    clock_1ms,
    input  logic                    rst,
    input  ms6205_pkg::key_state_t  keys,
    input  logic [2:0]              dpc_state,
    input  ms6205_pkg::cell_t       host_cell,
    input  logic                    host_valid,
    output logic                    host_ready,
    output ms6205_pkg::bus_t        disp_bus,
    output logic                    disp_req,
    input  logic                    disp_ack,
    output ms6205_pkg::view_t       view,
    output logic                    marker
);

    ms6205_pkg::cell_t  push_cell;
    logic               push_valid;
    logic               push_ready;
    ms6205_pkg::cell_t  pop_cell;
    logic               pop_valid;
    logic               pop_ready;

    view_controller #(
        .columns (columns),
        .rows    (rows)
    ) view_controller_inst (
        .clock_1ms  (clock_1ms),
        .rst        (rst),
        .keys       (keys),
        .dpc_state  (dpc_state),
        .host_cell  (host_cell),
        .host_valid (host_valid),
        .host_ready (host_ready),
        .push_cell  (push_cell),
        .push_valid (push_valid),
        .push_ready (push_ready),
        .view       (view),
        .marker     (marker)
    );

    cell_fifo #(
        .fifo_depth (fifo_depth)
    ) cell_fifo_inst (
        .clock_1ms  (clock_1ms),
        .rst        (rst),
        .push_cell  (push_cell),
        .push_valid (push_valid),
        .push_ready (push_ready),
        .pop_cell   (pop_cell),
        .pop_valid  (pop_valid),
        .pop_ready  (pop_ready)
    );

    display_writer display_writer_inst (
        .clock_1ms  (clock_1ms),
        .rst        (rst),
        .pop_cell   (pop_cell),
        .pop_valid  (pop_valid),
        .pop_ready  (pop_ready),
        .disp_bus   (disp_bus),
        .disp_req   (disp_req),
        .disp_ack   (disp_ack)
    );

endmodule

/* verif/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter real period_ns = 40.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always begin
        #(period_ns / 2.0) clk = ~clk; // one edge every half period.
    end

endmodule

/* verif/ms6205_tb.sv */
`timescale 1ns/10ps

module ms6205_tb;

    localparam int columns = 16;
    localparam int rows = 10;
    localparam int fifo_depth = 8;
    localparam int n_cells = columns * rows;
    localparam int n_host_writes = 110;
    localparam int cycle_limit = 40 * (2 * n_cells + n_host_writes);

    logic                    clk;
    logic                    rst;
    ms6205_pkg::key_state_t  keys;
    logic [2:0]              dpc_state;
    ms6205_pkg::cell_t       host_cell;
    logic                    host_valid;
    logic                    host_ready;
    ms6205_pkg::bus_t        disp_bus;
    logic                    disp_req;
    logic                    disp_ack;
    ms6205_pkg::view_t       view;
    logic                    marker;

    integer seed = 32'h1ff9_e6df;
    int cycles = 0;
    int stall_cycles = 0;
    logic slow_ack = 1'b0;
    logic reset_sweep_due = 1'b0;
    logic prev_req = 1'b0;
    logic prev_ack = 1'b0;
    ms6205_pkg::cell_t exp_q[$];
    ms6205_pkg::bus_t got_q[$];
    logic [6:0] screen [n_cells];
    logic [6:0] model_screen [n_cells];

    tb_clock_gen #(.period_ns(40.0)) clock_gen_inst (.clk(clk));

    ms6205_top #(
        .columns    (columns),
        .rows       (rows),
        .fifo_depth (fifo_depth)
    ) ms6205_top_inst (
        .clock_1ms  (clk),
        .rst        (rst),
        .keys       (keys),
        .dpc_state  (dpc_state),
        .host_cell  (host_cell),
        .host_valid (host_valid),
        .host_ready (host_ready),
        .disp_bus   (disp_bus),
        .disp_req   (disp_req),
        .disp_ack   (disp_ack),
        .view       (view),
        .marker     (marker)
    );

    // the display stores a blank for symbol zero.
    function automatic ms6205_pkg::cell_t ref_cell(ms6205_pkg::cell_t c);
        ms6205_pkg::cell_t r;
        r = c;
        if (c.code == 7'd0) begin
            r.code = 7'h20;
        end
        return r;
    endfunction

    function automatic int ack_delay();
        if (slow_ack) begin
            return 3 + int'({$random(seed)} % 3);
        end
        return int'({$random(seed)} % 6);
    endfunction

    function automatic ms6205_pkg::key_state_t key_bit(int idx);
        ms6205_pkg::key_state_t k;
        k = '0;
        k[idx] = 1'b1;
        return k;
    endfunction

    task automatic abort_run(string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_cell(string name, ms6205_pkg::cell_t exp, ms6205_pkg::cell_t act);
        if (act !== exp) begin
            abort_run($sformatf("[ERROR] %s: expected addr %0d code %02h, actual addr %0d code %02h",
                                name, exp.addr, exp.code, act.addr, act.code));
        end
    endtask

    task automatic check_view(string name, ms6205_pkg::view_t exp, ms6205_pkg::view_t act);
        if (act !== exp) begin
            abort_run($sformatf("[ERROR] %s: expected %s, actual %s", name, exp.name(), act.name()));
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            abort_run($sformatf("[ERROR] %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic wait_cycles(int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic queue_sweep();
        ms6205_pkg::cell_t c;
        for (int a = 0; a < n_cells; a++) begin
            c.addr = 8'(a);
            c.code = 7'h20;
            exp_q.push_back(c);
            model_screen[a] = 7'h20;
        end
    endtask

    task automatic host_write(ms6205_pkg::cell_t c);
        host_cell  <= c;
        host_valid <= 1'b1;
        do @(posedge clk); while (!host_ready);
    endtask

    task automatic random_writes(int n);
        ms6205_pkg::cell_t c;
        for (int i = 0; i < n; i++) begin
            c.addr = 8'({$random(seed)} % n_cells);
            c.code = (({$random(seed)} % 5) == 0) ? 7'd0 : 7'({$random(seed)} % 128);
            host_write(c);
        end
        host_valid <= 1'b0;
    endtask

    task automatic drain();
        wait_cycles(2);
        while (exp_q.size() != 0) @(posedge clk);
        while (disp_req || disp_ack) @(posedge clk);
    endtask

    task automatic press_key(ms6205_pkg::key_state_t k);
        keys <= k;
        @(posedge clk);
        keys <= '0;
        @(posedge clk); // view register has taken the key by now.
    endtask

    task automatic compare_screen(string name);
        ms6205_pkg::cell_t want;
        ms6205_pkg::cell_t got;
        for (int a = 0; a < n_cells; a++) begin
            want.addr = 8'(a);
            want.code = model_screen[a];
            got.addr  = 8'(a);
            got.code  = screen[a];
            check_cell(name, want, got);
        end
    endtask

    task automatic sweep_views_and_dpc();
        int vkeys[4] = '{ms6205_pkg::key_iram, ms6205_pkg::key_dram,
                         ms6205_pkg::key_cin, ms6205_pkg::key_cout};
        ms6205_pkg::view_t vcodes[4] = '{ms6205_pkg::view_iram, ms6205_pkg::view_dram,
                                         ms6205_pkg::view_cin, ms6205_pkg::view_cout};
        logic [2:0] dpcs[6] = '{3'd0, 3'd1, 3'd2, 3'd3, 3'd5, 3'd7};
        for (int v = 0; v < 4; v++) begin
            press_key(key_bit(vkeys[v]));
            check_view("single view key", vcodes[v], view);
            for (int d = 0; d < 6; d++) begin
                dpc_state <= dpcs[d];
                @(posedge clk);
                check_bit("marker", (v == 0) && (dpcs[d] == 3'd2), marker);
            end
        end
    endtask

    // expected cells are queued in the order the DUT accepts them.
    always @(posedge clk) begin : accept_monitor
        ms6205_pkg::cell_t want;
        if (rst) begin
            reset_sweep_due <= 1'b1;
        end else begin
            if (reset_sweep_due || (keys[ms6205_pkg::key_hard_rst] && !keys[ms6205_pkg::key_iram]
                    && !keys[ms6205_pkg::key_dram] && !keys[ms6205_pkg::key_cin]
                    && !keys[ms6205_pkg::key_cout])) begin
                queue_sweep();
            end
            reset_sweep_due <= 1'b0;
            if (host_valid && host_ready) begin
                want = ref_cell(host_cell);
                exp_q.push_back(want);
                model_screen[want.addr] = want.code;
            end
            if (host_valid && !host_ready) begin
                stall_cycles <= stall_cycles + 1;
            end
        end
    end

    initial begin : display_responder
        disp_ack <= 1'b0;
        forever begin
            @(posedge clk);
            if (!rst && disp_req && !disp_ack) begin
                wait_cycles(ack_delay());
                disp_ack <= 1'b1;
                got_q.push_back(disp_bus);
                screen[disp_bus.addr] = ~disp_bus.data[6:0];
                do @(posedge clk); while (disp_req);
                wait_cycles(ack_delay());
                disp_ack <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin : compare_writes
        ms6205_pkg::bus_t word;
        ms6205_pkg::cell_t want;
        ms6205_pkg::cell_t got;
        while (got_q.size() != 0) begin
            word     = got_q.pop_front();
            got.addr = word.addr;
            got.code = ~word.data[6:0];
            check_bit("bus data top bit", 1'b0, word.data[7]);
            if (exp_q.size() == 0) begin
                abort_run("a display write arrived with no cell left to expect");
            end else begin
                want = exp_q.pop_front();
                check_cell("display write", want, got);
            end
        end
    end

    always @(posedge clk) begin : protocol_monitor
        if (!rst && prev_req && !disp_req && !prev_ack) begin
            abort_run("display req fell before ack rose");
        end else if (!rst && !prev_req && disp_req && disp_ack) begin
            abort_run("display req rose while ack was still high");
        end
        prev_req <= disp_req;
        prev_ack <= disp_ack;
    end

    always @(posedge clk) begin : cycle_guard
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            abort_run("the run took longer than its cycle limit");
        end
    end

    initial begin : stimulus
        int stalls_before;
        rst        <= 1'b1;
        keys       <= '0;
        dpc_state  <= '0;
        host_cell  <= '0;
        host_valid <= 1'b0;
        wait_cycles(16);
        check_bit("host_ready in reset", 1'b0, host_ready);
        rst <= 1'b0;
        drain();
        check_view("view after power-on sweep", ms6205_pkg::view_iram, view);

        random_writes(40);
        drain();
        compare_screen("screen after host writes");

        press_key(key_bit(ms6205_pkg::key_iram) | key_bit(ms6205_pkg::key_dram)
                  | key_bit(ms6205_pkg::key_cin) | key_bit(ms6205_pkg::key_cout)
                  | key_bit(ms6205_pkg::key_hard_rst));
        check_view("all keys", ms6205_pkg::view_iram, view);
        press_key(key_bit(ms6205_pkg::key_dram) | key_bit(ms6205_pkg::key_cin)
                  | key_bit(ms6205_pkg::key_cout) | key_bit(ms6205_pkg::key_hard_rst));
        check_view("dram over lower keys", ms6205_pkg::view_dram, view);
        press_key(key_bit(ms6205_pkg::key_cin) | key_bit(ms6205_pkg::key_cout)
                  | key_bit(ms6205_pkg::key_hard_rst));
        check_view("cin over lower keys", ms6205_pkg::view_cin, view);
        press_key(key_bit(ms6205_pkg::key_cout) | key_bit(ms6205_pkg::key_hard_rst));
        check_view("cout over hard reset", ms6205_pkg::view_cout, view);
        sweep_views_and_dpc();

        slow_ack = 1'b1; // long acks back the FIFO up.
        stalls_before = stall_cycles;
        random_writes(60);
        drain();
        slow_ack = 1'b0;
        if (stall_cycles == stalls_before) begin
            abort_run("host_ready never dropped while the display acked slowly");
        end
        compare_screen("screen after slow acks");

        dpc_state <= 3'd2;
        press_key(key_bit(ms6205_pkg::key_hard_rst));
        check_view("view after hard reset key", ms6205_pkg::view_restart, view);
        check_bit("host_ready during sweep", 1'b0, host_ready);
        check_bit("marker during sweep", 1'b0, marker);
        drain();
        check_view("view after second sweep", ms6205_pkg::view_iram, view);
        random_writes(10);
        drain();
        compare_screen("screen after hard reset");

        $display("Everything OK");
        $finish;
    end

endmodule

/* filelist.f */
rtl/ms6205_pkg.sv
rtl/view_controller.sv
rtl/cell_fifo.sv
rtl/display_writer.sv
rtl/ms6205_top.sv
verif/tb_clock_gen.sv
verif/ms6205_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS = --binary --timing --assert -j 0
TOP = ms6205_tb
FILELIST = filelist.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
